/* Bender.yml */
package:
  name: cpuCore

sources:
  - common/cpuPkg.sv
  - logic/alu.sv
  - processor/progCounter.sv
  - processor/regBank.sv
  - processor/busPort.sv
  - processor/controlFsm.sv
  - processor/cpuCore.sv
  - target: simulation
    files:
      - dv/memModels.sv
      - dv/cpuTb.sv

/* common/cpuPkg.sv */
package cpuPkg;

    ////////////////////////////////////////////////////////////////////
    // Widths and fixed addresses

    // Data and address paths share one width
    localparam int dataWidth = 8;

    typedef logic [dataWidth-1:0] byte_t;

    // ROM locations that hold the thread start address per interrupt line
    localparam byte_t irq0Vector = 8'hFF;
    localparam byte_t irq1Vector = 8'hFE;

    // Bus address parked here whenever no access is running
    localparam byte_t busIdleAddr = 8'hFF;

    ////////////////////////////////////////////////////////////////////
    // Instruction encoding

    // ALU operation, upper nibble of an instruction byte
    // Codes C to F pass A through
    typedef enum logic [3:0] {
        add         = 4'h0,
        sub         = 4'h1,
        mul         = 4'h2,
        shiftLeftA  = 4'h3,
        shiftRightA = 4'h4,
        incA        = 4'h5,
        incB        = 4'h6,
        decA        = 4'h7,
        decB        = 4'h8,
        equal       = 4'h9,
        greater     = 4'hA,
        less        = 4'hB
    } aluOp_t;

    // Instruction class, lower nibble
    // 9 and A are illegal and stall the core
    typedef enum logic [3:0] {
        loadA    = 4'h0,
        loadB    = 4'h1,
        storeA   = 4'h2,
        storeB   = 4'h3,
        aluToA   = 4'h4,
        aluToB   = 4'h5,
        branchIf = 4'h6,
        goto     = 4'h7,
        goIdle   = 4'h8,
        derefA   = 4'hB,
        derefB   = 4'hC
    } instrClass_t;

    // One ROM byte, seen as an opcode or as an operand
    typedef union packed {
        struct packed {
            aluOp_t      aluOp;
            instrClass_t instrClass;
        } instr;
        byte_t operand;
    } romWord_u;

    ////////////////////////////////////////////////////////////////////
    // Controller state and per-cycle commands

    typedef enum logic [4:0] {
        idle, threadStart0, threadStart1, threadStart2, choose,
        loadToA, loadToB, load0, load1, load2,
        storeFromA, storeFromB, store0,
        aluSaveA, aluSaveB, aluWait,
        branchTest, branchLoad, branchWait,
        gotoStart, gotoLoad, gotoWait,
        derefToA, derefToB, deref0, deref1
    } cpuState_t;

    typedef enum logic [2:0] {
        pcHold, pcInc1, pcInc2, pcLoadRom, pcVector0, pcVector1
    } pcOp_t;

    typedef struct packed {
        pcOp_t op;
        logic  operandOffset;
    } pcCmd_t;

    typedef struct packed {
        logic aluToA;
        logic aluToB;
        logic busToSelected;
        logic selectLoad;
        logic selectValue;
    } regCmd_t;

    typedef enum logic [1:0] {srcIdle, srcRom, srcRegA, srcRegB} busAddrSrc_t;

    typedef struct packed {
        busAddrSrc_t addrSrc;
        logic        write;
    } busCmd_t;

endpackage

/* cpuCore.f */
common/cpuPkg.sv
logic/alu.sv
processor/progCounter.sv
processor/regBank.sv
processor/busPort.sv
processor/controlFsm.sv
processor/cpuCore.sv
dv/memModels.sv
dv/cpuTb.sv

/* dv/cpuStimulus.txt */
// 000: ROM image, @ moves to a new address
// 100: write count, then address and data of each expected bus write
// 180: event count, then raise mask and total writes once it is served
// 1C0: final regA and regB
@000
08          // idle until the first interrupt
@010
A6 80       // branch if A > B to the illegal opcode
00 20       // loadA from 20
01 05       // loadB from 05
04          // A = A + B
15          // B = A - B
02 30       // storeA to 30
03 31       // storeB to 31
B5          // B = A < B
03 32       // storeB to 32
96 25       // branch if A == B, not taken
02 01       // storeA to 01
56 28       // branch if A + 1 nonzero, taken
03 3F       // skipped by the branch
00
07 2E       // goto 2E
02 3E       // skipped by the goto
@02E
0B 0C       // derefA then derefB
02 34 03 35 // store both to 34 and 35
08          // goIdle
@060
00 34 65    // loadA from 34, B = B + 1
03 36 24    // storeB to 36, A = A * B
02 37 01 32 // storeA to 37, loadB from 32
08          // goIdle
@080
0A          // illegal opcode
@0FE
60 10       // thread vectors for line 1 and line 0
@100
08 30 D9 31 DF 32 01 01 D9 34 26 35 D9 36 DA 37 5C
@180
02 03 08 01 08
@1C0
5C 01

/* dv/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;
    import cpuPkg::*;

    localparam int clockPeriod  = 100;
    localparam int quietCycles  = 30;
    localparam int ackTimeout   = 200;
    localparam int writeTimeout = 400;

    // Sections of the stimulus image
    localparam int romBase   = 'h000;
    localparam int writeBase = 'h100;
    localparam int eventBase = 'h180;
    localparam int finalBase = 'h1C0;

    // One expected bus write
    typedef struct packed {
        byte_t addr;
        byte_t data;
    } busWrite_t;

    logic       CLK;
    logic       RESET;
    logic [1:0] interruptRaise;
    logic [1:0] interruptAck;
    logic       busWe;
    byte_t      romAddress;
    byte_t      romData;
    byte_t      busAddr;
    byte_t      regA;
    byte_t      regB;
    wire byte_t busData;

    byte_t     stimBytes [0:511];
    busWrite_t expectedWrites [$];
    int        writeTotal;
    int        eventTotal;
    int        stimLength;
    int        writeCount;
    int        checkCount;
    int        errorCount;

    cpuCore cpuCore_inst (
        .CLK, .RESET, .romData, .interruptRaise, .romAddress,
        .busAddr, .busWe, .interruptAck, .regA, .regB, .busData
    );

    romModel romModel_inst (.CLK, .romAddress, .romData);

    busRamModel busRamModel_inst (.CLK, .busAddr, .busWe, .busData);

    initial begin
        CLK = 1'b0;
        forever begin
            #(clockPeriod / 2) CLK = ~CLK;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checking and reporting

    task automatic compareByte(input string name, input byte_t expected, input byte_t actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error at %0t: %s expected %02h, actual %02h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic reportFailure(input string what);
        errorCount++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    task automatic printSummary();
        $display("Checks run: %0d, bus writes seen: %0d, errors: %0d",
                 checkCount, writeCount, errorCount);
    endtask

    // Every write strobe is matched against the next listed write
    always @(negedge CLK) begin
        if (busWe === 1'b1) begin
            if (writeCount >= expectedWrites.size()) begin
                reportFailure($sformatf("unexpected bus write of %02h to address %02h",
                                        busData, busAddr));
            end else begin
                compareByte("busAddr", expectedWrites[writeCount].addr, busAddr);
                compareByte("busData", expectedWrites[writeCount].data, busData);
            end
            writeCount++;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus handling

    task automatic loadStimulus();
        busWrite_t entry;
        for (int i = 0; i < 512; i++) begin
            stimBytes[i] = '0;
        end
        $readmemh("dv/cpuStimulus.txt", stimBytes);
        for (int i = 0; i < 256; i++) begin
            romModel_inst.mem[i] = stimBytes[romBase + i];
        end
        writeTotal = stimBytes[writeBase];
        for (int i = 0; i < writeTotal; i++) begin
            entry.addr = stimBytes[writeBase + 1 + 2 * i];
            entry.data = stimBytes[writeBase + 2 + 2 * i];
            expectedWrites.push_back(entry);
        end
        eventTotal = stimBytes[eventBase];
        stimLength = writeTotal + eventTotal;
    endtask

    // Returns on the falling edge where the ack shows up
    task automatic waitForAck(input logic [1:0] expectedAck);
        int cycles;
        cycles = 0;
        @(negedge CLK);
        while (interruptAck === 2'b00 && cycles < ackTimeout) begin
            @(negedge CLK);
            cycles++;
        end
        if (interruptAck === 2'b00) begin
            reportFailure("no interrupt ack arrived in time");
        end else begin
            compareByte("interruptAck", byte_t'(expectedAck), byte_t'(interruptAck));
        end
    endtask

    task automatic waitForWrites(input int target);
        int cycles;
        cycles = 0;
        do begin
            @(posedge CLK);
            cycles++;
        end while (writeCount < target && cycles < writeTimeout);
        if (writeCount < target) begin
            reportFailure("the listed bus writes did not all arrive");
        end
    endtask

    // Core sits idle or stalled and the write count must not move
    task automatic expectQuiet(input int target);
        repeat (quietCycles) @(posedge CLK);
        compareByte("bus write count", byte_t'(target), byte_t'(writeCount));
    endtask

    task automatic serveInterrupts(input logic [1:0] mask, input int target);
        logic [1:0] pending;
        logic [1:0] expectedAck;
        pending = mask;
        @(negedge CLK);
        interruptRaise = mask;
        while (pending != 2'b00) begin
            // Line 0 wins over line 1
            expectedAck = pending[0] ? 2'b01 : 2'b10;
            waitForAck(expectedAck);
            pending = pending & ~expectedAck;
            // Drop the served line right on its ack
            interruptRaise = pending;
            @(negedge CLK);
            compareByte("interruptAck pulse end", 8'h00, byte_t'(interruptAck));
        end
        waitForWrites(target);
        expectQuiet(target);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        RESET          = 1'b1;
        interruptRaise = 2'b00;
        writeCount     = 0;
        checkCount     = 0;
        errorCount     = 0;
        loadStimulus();
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        // State right out of reset
        compareByte("busWe", 8'h00, byte_t'(busWe));
        compareByte("interruptAck", 8'h00, byte_t'(interruptAck));
        compareByte("busAddr", busIdleAddr, busAddr);
        compareByte("regA", 8'h00, regA);
        compareByte("regB", 8'h00, regB);
        // Fetch starts at PC 0
        compareByte("romAddress", 8'h00, romAddress);

        // Program at 0 parks the core in idle
        expectQuiet(0);

        for (int e = 0; e < eventTotal; e++) begin
            serveInterrupts(stimBytes[eventBase + 1 + 2 * e][1:0],
                            stimBytes[eventBase + 2 + 2 * e]);
        end

        compareByte("bus write count", byte_t'(writeTotal), byte_t'(writeCount));
        compareByte("regA", stimBytes[finalBase], regA);
        compareByte("regB", stimBytes[finalBase + 1], regB);

        printSummary();
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Budget of 40 cycles per listed write and interrupt event
    initial begin
        @(negedge RESET);
        repeat (stimLength * 40) @(posedge CLK);
        $display("Watchdog expired, the run did not finish within %0d cycles",
                 stimLength * 40);
        errorCount++;
        printSummary();
        $display("Simulation failed");
        $finish;
    end

endmodule

/* dv/memModels.sv */
`timescale 1ns/1ps

//////////////////////////////////////////////////////////////////////
// Program ROM

// Synchronous read, data for an address shows up one edge later
module romModel (
    input  logic          CLK,
    input  cpuPkg::byte_t romAddress,
    output cpuPkg::byte_t romData
);
    import cpuPkg::*;

    // Written by the testbench before the first clock edge
    byte_t mem [0:255];

    always @(posedge CLK) begin
        romData <= mem[romAddress];
    end

endmodule

//////////////////////////////////////////////////////////////////////
// Data RAM on the tristate bus

module busRamModel (
    input  logic               CLK,
    input  cpuPkg::byte_t      busAddr,
    input  logic               busWe,
    inout  wire cpuPkg::byte_t busData
);
    import cpuPkg::*;

    byte_t mem [0:255];
    byte_t readData;

    // Each location starts as the inverse of its own address
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = ~byte_t'(i);
        end
    end

    // Write on the strobe edge, read one cycle after the address
    always @(posedge CLK) begin
        if (busWe) begin
            mem[busAddr] <= busData;
        end
        readData <= mem[busAddr];
    end

    // Core owns the bus while it writes
    assign busData = busWe ? 'z : readData;

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic          CLK,
    input  logic          RESET,
    input  cpuPkg::byte_t romData,
    input  cpuPkg::byte_t regA,
    input  cpuPkg::byte_t regB,
    output cpuPkg::byte_t result
);
    import cpuPkg::*;

    romWord_u romWord;
    byte_t    resultNext;

    // Operation sits in the upper nibble of the opcode
    assign romWord = romData;

    always_comb begin
        case (romWord.instr.aluOp)
            add:         resultNext = regA + regB;
            sub:         resultNext = regA - regB;
            // Low byte of the product only
            mul:         resultNext = regA * regB;
            shiftLeftA:  resultNext = regA << 1;
            shiftRightA: resultNext = regA >> 1;
            incA:        resultNext = regA + 8'd1;
            incB:        resultNext = regB + 8'd1;
            decA:        resultNext = regA - 8'd1;
            decB:        resultNext = regB - 8'd1;
            // Compares give 1 or 0
            equal:       resultNext = byte_t'(regA == regB);
            greater:     resultNext = byte_t'(regA > regB);
            less:        resultNext = byte_t'(regA < regB);
            default:     resultNext = regA;
        endcase
    end

    // One cycle of latency, sampled every clock
    always_ff @(posedge CLK) begin
        if (RESET) begin
            result <= '0;
        end else begin
            result <= resultNext;
        end
    end

endmodule

/* processor/busPort.sv */
`timescale 1ns/1ps

module busPort (
    input  logic               CLK,
    input  logic               RESET,
    input  cpuPkg::busCmd_t    cmd,
    input  cpuPkg::byte_t      romData,
    input  cpuPkg::byte_t      regA,
    input  cpuPkg::byte_t      regB,
    input  cpuPkg::byte_t      selectedReg,
    output cpuPkg::byte_t      busAddr,
    output logic               busWe,
    output cpuPkg::byte_t      busIn,
    inout  wire cpuPkg::byte_t busData
);
    import cpuPkg::*;

    byte_t addrNext;
    byte_t writeData;

    always_comb begin
        case (cmd.addrSrc)
            srcRom:  addrNext = romData;
            srcRegA: addrNext = regA;
            srcRegB: addrNext = regB;
            default: addrNext = busIdleAddr;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busAddr <= busIdleAddr;
            busWe   <= 1'b0;
        end else begin
            busAddr <= addrNext;
            busWe   <= cmd.write;
        end
    end

    // Store data captured alongside the address
    always_ff @(posedge CLK) begin
        if (cmd.write) begin
            writeData <= selectedReg;
        end
    end

    // Bus is released whenever no write is in progress
    assign busData = busWe ? writeData : 'z;
    assign busIn   = busData;

endmodule

/* processor/controlFsm.sv */
`timescale 1ns/1ps

module controlFsm (
    input  logic            CLK,
    input  logic            RESET,
    input  cpuPkg::byte_t   romData,
    input  cpuPkg::byte_t   aluResult,
    input  logic [1:0]      interruptRaise,
    output cpuPkg::pcCmd_t  pcCmd,
    output cpuPkg::regCmd_t regCmd,
    output cpuPkg::busCmd_t busCmd,
    output logic [1:0]      interruptAck
);
    import cpuPkg::*;

    cpuState_t  state;
    cpuState_t  nextState;
    logic [1:0] nextAck;
    romWord_u   romWord;

    // Opcode view of the current ROM byte
    assign romWord = romData;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state        <= choose;
            interruptAck <= 2'b00;
        end else begin
            state        <= nextState;
            interruptAck <= nextAck;
        end
    end

    always_comb begin
        // Quiet defaults that each state overrides as needed
        nextState            = state;
        nextAck              = 2'b00;
        pcCmd.op             = pcHold;
        pcCmd.operandOffset  = 1'b0;
        regCmd               = '0;
        busCmd.addrSrc       = srcIdle;
        busCmd.write         = 1'b0;

        case (state)
            //////////////////////////////////////////////////////////////////
            // Thread start

            // Line 0 wins when both rise together
            idle: begin
                if (interruptRaise[0]) begin
                    nextState = threadStart0;
                    pcCmd.op  = pcVector0;
                    nextAck   = 2'b01;
                end else if (interruptRaise[1]) begin
                    nextState = threadStart0;
                    pcCmd.op  = pcVector1;
                    nextAck   = 2'b10;
                end
            end
            // Vector address is on the ROM while its byte comes back
            threadStart0: nextState = threadStart1;
            threadStart1: begin
                nextState = threadStart2;
                pcCmd.op  = pcLoadRom;
            end
            // First opcode of the thread is being fetched
            threadStart2: nextState = choose;

            //////////////////////////////////////////////////////////////////
            // Decode

            choose: begin
                // Point the ROM at the operand byte
                pcCmd.operandOffset = 1'b1;
                case (romWord.instr.instrClass)
                    loadA:    nextState = loadToA;
                    loadB:    nextState = loadToB;
                    storeA:   nextState = storeFromA;
                    storeB:   nextState = storeFromB;
                    aluToA:   nextState = aluSaveA;
                    aluToB:   nextState = aluSaveB;
                    branchIf: nextState = branchTest;
                    goto:     nextState = gotoStart;
                    goIdle:   nextState = idle;
                    derefA:   nextState = derefToA;
                    derefB:   nextState = derefToB;
                    // Illegal code parks the core here with the opcode kept on the ROM
                    default: begin
                        nextState           = choose;
                        pcCmd.operandOffset = 1'b0;
                    end
                endcase
            end

            //////////////////////////////////////////////////////////////////
            // Memory transfers

            loadToA, loadToB: begin
                nextState          = load0;
                regCmd.selectLoad  = 1'b1;
                regCmd.selectValue = (state == loadToB);
            end
            // Operand byte is the bus address
            load0: begin
                nextState      = load1;
                busCmd.addrSrc = srcRom;
            end
            // Bump early so the next opcode is ready in choose
            load1: begin
                nextState = load2;
                pcCmd.op  = pcInc2;
            end
            load2: begin
                nextState            = choose;
                regCmd.busToSelected = 1'b1;
            end

            storeFromA, storeFromB: begin
                nextState          = store0;
                regCmd.selectLoad  = 1'b1;
                regCmd.selectValue = (state == storeFromB);
                pcCmd.op           = pcInc2;
            end
            // Write strobe goes out on the following cycle
            store0: begin
                nextState      = choose;
                busCmd.addrSrc = srcRom;
                busCmd.write   = 1'b1;
            end

            //////////////////////////////////////////////////////////////////
            // ALU and flow control

            // Result was registered during choose
            aluSaveA, aluSaveB: begin
                nextState     = aluWait;
                regCmd.aluToA = (state == aluSaveA);
                regCmd.aluToB = (state == aluSaveB);
                pcCmd.op      = pcInc1;
            end
            aluWait: nextState = choose;

            branchTest: begin
                if (aluResult != '0) begin
                    nextState = branchLoad;
                end else begin
                    nextState = branchWait;
                    pcCmd.op  = pcInc2;
                end
            end
            branchLoad: begin
                nextState = branchWait;
                pcCmd.op  = pcLoadRom;
            end
            branchWait: nextState = choose;

            gotoStart: nextState = gotoLoad;
            gotoLoad: begin
                nextState = gotoWait;
                pcCmd.op  = pcLoadRom;
            end
            gotoWait: nextState = choose;

            // Register contents used as a RAM pointer
            derefToA, derefToB: begin
                nextState          = deref0;
                regCmd.selectLoad  = 1'b1;
                regCmd.selectValue = (state == derefToB);
                busCmd.addrSrc     = (state == derefToB) ? srcRegB : srcRegA;
            end
            deref0: begin
                nextState = deref1;
                pcCmd.op  = pcInc1;
            end
            deref1: begin
                nextState            = choose;
                regCmd.busToSelected = 1'b1;
            end

            default: nextState = choose;
        endcase
    end

endmodule

/* processor/cpuCore.sv */
`timescale 1ns/1ps

module cpuCore (
    input  logic               CLK,
    input  logic               RESET,
    input  cpuPkg::byte_t      romData,
    input  logic [1:0]         interruptRaise,
    output cpuPkg::byte_t      romAddress,
    output cpuPkg::byte_t      busAddr,
    output logic               busWe,
    output logic [1:0]         interruptAck,
    output cpuPkg::byte_t      regA,
    output cpuPkg::byte_t      regB,
    inout  wire cpuPkg::byte_t busData
);
    import cpuPkg::*;

    // Commands from the sequencer, applied at the next edge
    pcCmd_t  pcCmd;
    regCmd_t regCmd;
    busCmd_t busCmd;

    // Datapath links
    byte_t aluResult;
    byte_t selectedReg;
    byte_t busIn;

    controlFsm controlFsm_inst (
        .CLK, .RESET, .romData, .aluResult, .interruptRaise,
        .pcCmd, .regCmd, .busCmd, .interruptAck
    );

    progCounter progCounter_inst (
        .CLK, .RESET, .cmd(pcCmd), .romData, .romAddress
    );

    regBank regBank_inst (
        .CLK, .RESET, .cmd(regCmd), .aluResult, .busIn,
        .regA, .regB, .selectedReg
    );

    // Address, write data and tristate control for the data bus
    busPort busPort_inst (
        .CLK, .RESET, .cmd(busCmd), .romData, .regA, .regB, .selectedReg,
        .busAddr, .busWe, .busIn, .busData
    );

    // Opcode comes straight off the ROM
    alu alu_inst (
        .CLK, .RESET, .romData, .regA, .regB, .result(aluResult)
    );

endmodule

/* processor/progCounter.sv */
`timescale 1ns/1ps

module progCounter (
    input  logic           CLK,
    input  logic           RESET,
    input  cpuPkg::pcCmd_t cmd,
    input  cpuPkg::byte_t  romData,
    output cpuPkg::byte_t  romAddress
);
    import cpuPkg::*;

    byte_t pc;
    // Selects the operand byte after the opcode
    logic  offset;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc     <= '0;
            offset <= 1'b0;
        end else begin
            // Offset lasts one cycle unless asked again
            offset <= cmd.operandOffset;
            case (cmd.op)
                pcInc1:    pc <= pc + 8'd1;
                // Skip opcode and operand
                pcInc2:    pc <= pc + 8'd2;
                // Jump target or thread start read from ROM
                pcLoadRom: pc <= romData;
                pcVector0: pc <= irq0Vector;
                pcVector1: pc <= irq1Vector;
                default:   pc <= pc;
            endcase
        end
    end

    // ROM is synchronous, data for this address shows up next cycle
    assign romAddress = pc + byte_t'(offset);

endmodule

/* processor/regBank.sv */
`timescale 1ns/1ps

module regBank (
    input  logic            CLK,
    input  logic            RESET,
    input  cpuPkg::regCmd_t cmd,
    input  cpuPkg::byte_t   aluResult,
    input  cpuPkg::byte_t   busIn,
    output cpuPkg::byte_t   regA,
    output cpuPkg::byte_t   regB,
    output cpuPkg::byte_t   selectedReg
);
    import cpuPkg::*;

    // Low picks A, high picks B
    logic selectFlag;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            regA       <= '0;
            regB       <= '0;
            selectFlag <= 1'b0;
        end else begin
            if (cmd.selectLoad) begin
                selectFlag <= cmd.selectValue;
            end
            // ALU write-back takes precedence over bus data
            if (cmd.aluToA) begin
                regA <= aluResult;
            end else if (cmd.busToSelected && !selectFlag) begin
                regA <= busIn;
            end
            if (cmd.aluToB) begin
                regB <= aluResult;
            end else if (cmd.busToSelected && selectFlag) begin
                regB <= busIn;
            end
        end
    end

    // Source for store data
    assign selectedReg = selectFlag ? regB : regA;

endmodule
